// File: ldpc_qc.f
logic/ldpc_qc_pkg.sv
logic/qc_entry_if.sv
logic/parity_sequencer.sv
logic/block_buffer.sv
logic/cyclic_shift.sv
logic/syndrome_accum.sv
logic/ldpc_syndrome_top.sv
testbench/ldpc_syndrome_checker.sv
testbench/ldpc_syndrome_tb.sv

// File: run_sim.sh
#!/bin/sh
# builds the syndrome checker testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

TOP=ldpc_syndrome_tb
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
	--top-module "$TOP" -f ldpc_qc.f -Mdir obj_dir -o ldpc_sim
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

# a failing bound assertion must not stop the run before the summary
./obj_dir/ldpc_sim +verilator+error+limit+1000 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "TESTS PASSED" "$LOG"; then
	exit 0
fi
echo "pass message not found in $LOG"
exit 1

// File: testbench/ldpc_syndrome_tb.sv
`timescale 1ns/100ps
`default_nettype none

module ldpc_syndrome_tb;
	import ldpc_qc_pkg::*;

	localparam int CHD         = 360;
	localparam int IND         = 1;
	localparam int W           = CHD * IND;
	localparam int PERIOD      = 8;
	localparam int N_RUNS      = 6;
	localparam int RUN_CYC     = N_BCOL + N_ENT + 10;	// load, issue, drain, slack
	localparam int LIMIT_NS    = N_RUNS * RUN_CYC * PERIOD * 2;
	localparam int FILL_ZERO   = 0;
	localparam int FILL_ONES   = 1;
	localparam int FILL_RANDOM = 2;

	logic             sys_clk;
	logic             rst_n;
	logic             blk_wr;
	logic [COL_W-1:0] blk_addr;
	logic [W-1:0]     blk_data;
	logic             start;
	logic             busy;
	logic             synd_valid;
	logic [ROW_W-1:0] synd_row;
	logic [W-1:0]     synd_data;
	logic             synd_zero;
	logic             done;
	logic             check_ok;

	logic [31:0]  lfsr;
	logic [W-1:0] blocks [N_BCOL];	// codeword as written to the DUT
	logic [W-1:0] exp_synd [N_BROW];
	logic         exp_ok;
	int           runs_started;
	int           done_seen;
	int           row_seen;	// syndromes seen in the open run
	int           mon_checks;
	int           mon_errors;
	int           seq_checks;
	int           seq_errors;
	int           timeouts;

	ldpc_syndrome_top #(
		.CHD (CHD),
		.IND (IND)
	) uut (
		.sys_clk    (sys_clk),
		.rst_n      (rst_n),
		.blk_wr     (blk_wr),
		.blk_addr   (blk_addr),
		.blk_data   (blk_data),
		.start      (start),
		.busy       (busy),
		.synd_valid (synd_valid),
		.synd_row   (synd_row),
		.synd_data  (synd_data),
		.synd_zero  (synd_zero),
		.done       (done),
		.check_ok   (check_ok)
	);

	always #(PERIOD / 2) sys_clk = ~sys_clk;

	// x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	// lane i lands on lane i+s, wrapping past the MSB
	function automatic logic [W-1:0] rotate_up(input logic [W-1:0] x, input int s);
		logic [W-1:0] r;
		for (int i = 0; i < W; i++)
			r[(i + s * IND) % W] = x[i];
		return r;
	endfunction

	task automatic compute_expected();
		hb_entry_t e;
		exp_ok = 1'b1;
		for (int r = 0; r < N_BROW; r++)
			exp_synd[r] = '0;
		for (int k = 0; k < N_ENT; k++) begin
			e = HB_TABLE[k];
			exp_synd[e.row] = exp_synd[e.row] ^ rotate_up(blocks[e.col], int'(e.shift));
		end
		for (int r = 0; r < N_BROW; r++)
			if (exp_synd[r] != '0)
				exp_ok = 1'b0;
	endtask

	task automatic load_codeword(input int fill);
		logic [W-1:0] blk;
		for (int c = 0; c < N_BCOL; c++) begin
			blk = '0;
			if (fill == FILL_ONES)
				blk = '1;
			else if (fill == FILL_RANDOM)
				for (int i = 0; i < W; i++) begin
					lfsr   = lfsr_step(lfsr);
					blk[i] = lfsr[0];
				end
			@(negedge sys_clk);
			blk_wr    = 1'b1;
			blk_addr  = COL_W'(c);
			blk_data  = blk;
			blocks[c] = blk;
		end
		@(negedge sys_clk);
		blk_wr   = 1'b0;
		blk_data = '0;
	endtask

	task automatic run_check(input bit stray_start);
		int waited;
		compute_expected();
		@(negedge sys_clk);
		start        = 1'b1;
		runs_started = runs_started + 1;
		@(negedge sys_clk);
		start = 1'b0;
		if (stray_start) begin
			repeat (3) @(negedge sys_clk);
			seq_checks++;
			assert (busy) else begin
				seq_errors++;
				$display("Error at %0t: busy low while a run should be active", $time);
			end
			start = 1'b1;	// dropped, the run is busy
			@(negedge sys_clk);
			start = 1'b0;
		end
		waited = 0;
		while (done_seen < runs_started && waited < RUN_CYC) begin
			@(negedge sys_clk);
			waited++;
		end
		if (done_seen < runs_started) begin
			timeouts++;
			$display("run %0d gave no done within %0d cycles", runs_started, RUN_CYC);
		end
		repeat (2) @(negedge sys_clk);
		seq_checks++;
		assert (!busy && check_ok == exp_ok) else begin
			seq_errors++;
			$display("Error at %0t: busy %0b check_ok %0b after done, expected 0 and %0b",
				$time, busy, check_ok, exp_ok);
		end
	endtask

	// outputs only move on the rising edge
	always @(negedge sys_clk) begin
		int exp_row;
		exp_row = (row_seen < N_BROW) ? row_seen : N_BROW - 1;
		if (rst_n && synd_valid) begin
			mon_checks++;
			assert (runs_started > done_seen && row_seen < N_BROW) else begin
				mon_errors++;
				$display("Error at %0t: row syndrome outside a run or past the last row", $time);
			end
			assert (synd_row == ROW_W'(exp_row)) else begin
				mon_errors++;
				$display("Error at %0t: synd_row %0d, expected %0d", $time, synd_row, exp_row);
			end
			assert (synd_data == exp_synd[exp_row]) else begin
				mon_errors++;
				$display("Error at %0t: synd_data wrong on row %0d", $time, exp_row);
			end
			assert (synd_zero == (exp_synd[exp_row] == '0)) else begin
				mon_errors++;
				$display("Error at %0t: synd_zero %0b on row %0d", $time, synd_zero, exp_row);
			end
			row_seen = row_seen + 1;
		end
		if (rst_n && done) begin
			mon_checks++;
			assert (runs_started > done_seen && row_seen == N_BROW) else begin
				mon_errors++;
				$display("Error at %0t: done after %0d row syndromes", $time, row_seen);
			end
			assert (check_ok == exp_ok) else begin
				mon_errors++;
				$display("Error at %0t: check_ok %0b, expected %0b", $time, check_ok, exp_ok);
			end
			done_seen = done_seen + 1;
			row_seen  = 0;
		end
	end

	initial begin
		#(LIMIT_NS);
		$display("watchdog expired at %0t, the run did not finish", $time);
		$display("TESTS FAILED");
		$finish;
	end

	initial begin
		sys_clk  = 1'b0;
		rst_n    = 1'b0;
		blk_wr   = 1'b0;
		blk_addr = '0;
		blk_data = '0;
		start    = 1'b0;
		lfsr     = 32'h70db;
		repeat (2) @(posedge sys_clk);
		@(negedge sys_clk);
		rst_n = 1'b1;

		repeat (3) begin
			@(negedge sys_clk);
			seq_checks++;
			assert (!busy && !synd_valid && !done) else begin
				seq_errors++;
				$display("Error at %0t: outputs active before any start", $time);
			end
		end

		load_codeword(FILL_ZERO);	// every row clean
		run_check(1'b0);
		load_codeword(FILL_RANDOM);
		run_check(1'b1);
		load_codeword(FILL_RANDOM);
		run_check(1'b0);
		load_codeword(FILL_ONES);	// rows of odd weight fail, the others cancel
		run_check(1'b0);
		load_codeword(FILL_RANDOM);
		run_check(1'b1);
		load_codeword(FILL_RANDOM);
		run_check(1'b0);

		repeat (4) @(negedge sys_clk);
		seq_checks++;
		assert (done_seen == N_RUNS) else begin
			seq_errors++;
			$display("Error at %0t: %0d done pulses for %0d runs", $time, done_seen, N_RUNS);
		end

		$display("checks %0d, value errors %0d, timeouts %0d, assertion failures %0d",
			mon_checks + seq_checks, mon_errors + seq_errors, timeouts, uut.u_chk.fail_cnt);
		if (mon_errors + seq_errors + timeouts + uut.u_chk.fail_cnt == 0)
			$display("TESTS PASSED");
		else
			$display("TESTS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// File: testbench/ldpc_syndrome_checker.sv
`timescale 1ns/100ps
`default_nettype none

module ldpc_syndrome_checker (
	input wire                          sys_clk,
	input wire                          rst_n,
	input wire                          start,
	input wire                          busy,
	input wire                          synd_valid,
	input wire [ldpc_qc_pkg::ROW_W-1:0] synd_row,
	input wire                          done,
	input wire                          check_ok
);
	import ldpc_qc_pkg::*;

	localparam int BUSY_CYC = N_ENT + 3;	// issue plus three pipeline stages

	int   fail_cnt = 0;	// failed assertions so far
	int   busy_len;	// cycles since busy rose
	logic last_row;

	assign last_row = synd_valid && (synd_row == ROW_W'(N_BROW - 1));

	always_ff @(posedge sys_clk) begin
		if (!rst_n)
			busy_len <= 0;
		else if (busy)
			busy_len <= busy_len + 1;
		else
			busy_len <= 0;
	end

	property p_reset_quiet;
		@(posedge sys_clk) !rst_n |=> !busy && !synd_valid && !done && !check_ok;
	endproperty

	property p_synd_in_run;
		@(posedge sys_clk) disable iff (!rst_n)
			synd_valid && !busy |-> synd_row == ROW_W'(N_BROW - 1);
	endproperty

	property p_done_after_last;
		@(posedge sys_clk) disable iff (!rst_n) last_row |=> done;
	endproperty

	property p_done_only_after_last;
		@(posedge sys_clk) disable iff (!rst_n) done |-> $past(last_row);
	endproperty

	// a dropped start leaves the run length unchanged
	property p_busy_len;
		@(posedge sys_clk) disable iff (!rst_n) busy |-> busy_len < BUSY_CYC;
	endproperty

	a_reset_quiet: assert property (p_reset_quiet) else begin
		$error("outputs active right after a reset cycle");
		fail_cnt = fail_cnt + 1;
	end

	a_synd_in_run: assert property (p_synd_in_run) else begin
		$error("row syndrome presented while idle");
		fail_cnt = fail_cnt + 1;
	end

	a_done_after_last: assert property (p_done_after_last) else begin
		$error("done missing after the last row syndrome");
		fail_cnt = fail_cnt + 1;
	end

	a_done_only_after_last: assert property (p_done_only_after_last) else begin
		$error("done without a last row syndrome before it");
		fail_cnt = fail_cnt + 1;
	end

	a_busy_len: assert property (p_busy_len) else begin
		$error("busy held longer than one run, start while busy restarted it");
		fail_cnt = fail_cnt + 1;
	end

endmodule

bind ldpc_syndrome_top ldpc_syndrome_checker u_chk (
	.sys_clk    (sys_clk),
	.rst_n      (rst_n),
	.start      (start),
	.busy       (busy),
	.synd_valid (synd_valid),
	.synd_row   (synd_row),
	.done       (done),
	.check_ok   (check_ok)
);

`default_nettype wire

// File: logic/ldpc_syndrome_top.sv
`timescale 1ns/100ps
`default_nettype none

module ldpc_syndrome_top #(
	parameter int CHD = 360,
	parameter int IND = 1
) (
	input wire                            sys_clk,
	input wire                            rst_n,
	input wire                            blk_wr,
	input wire [ldpc_qc_pkg::COL_W-1:0]   blk_addr,
	input wire [CHD*IND-1:0]              blk_data,
	input wire                            start,
	output logic                          busy,
	output logic                          synd_valid,
	output logic [ldpc_qc_pkg::ROW_W-1:0] synd_row,
	output logic [CHD*IND-1:0]            synd_data,
	output logic                          synd_zero,
	output logic                          done,
	output logic                          check_ok
);

	qc_entry_if ent_issue ();	// entry in its issue cycle
	qc_entry_if ent_read ();	// same entry, aligned with blk_q

	logic [CHD*IND-1:0] blk_q;
	logic [CHD*IND-1:0] shift_out;

	parity_sequencer u_seq (
		.sys_clk (sys_clk),
		.rst_n   (rst_n),
		.start   (start),
		.busy    (busy),
		.ent     (ent_issue)
	);

	block_buffer #(
		.CHD (CHD),
		.IND (IND)
	) u_buf (
		.sys_clk  (sys_clk),
		.rst_n    (rst_n),
		.blk_wr   (blk_wr),
		.blk_addr (blk_addr),
		.blk_data (blk_data),
		.ent_in   (ent_issue),
		.ent_out  (ent_read),
		.blk_q    (blk_q)
	);

	cyclic_shift #(
		.IND (IND),
		.CHD (CHD)
	) u_shift (
		.sys_clk     (sys_clk),
		.fs_en       (ent_read.valid),
		.rst_n       (rst_n),
		.shift_index (ent_read.shift),
		.din         (blk_q),
		.shift_out   (shift_out)
	);

	// accumulator sees the full lane-expanded block
	syndrome_accum #(
		.CHD (CHD*IND)
	) u_acc (
		.sys_clk    (sys_clk),
		.rst_n      (rst_n),
		.start      (start),
		.ent        (ent_read),
		.shift_out  (shift_out),
		.synd_valid (synd_valid),
		.synd_row   (synd_row),
		.synd_data  (synd_data),
		.synd_zero  (synd_zero),
		.done       (done),
		.check_ok   (check_ok)
	);

endmodule

`default_nettype wire

// File: logic/syndrome_accum.sv
`timescale 1ns/100ps
`default_nettype none

module syndrome_accum #(
	parameter int CHD = 360	// bits per row syndrome
) (
	input wire                            sys_clk,
	input wire                            rst_n,
	input wire                            start,
	qc_entry_if.dst                       ent,
	input wire [CHD-1:0]                  shift_out,
	output logic                          synd_valid,
	output logic [ldpc_qc_pkg::ROW_W-1:0] synd_row,
	output logic [CHD-1:0]                synd_data,
	output logic                          synd_zero,
	output logic                          done,
	output logic                          check_ok
);
	import ldpc_qc_pkg::*;

	logic             tag_valid;	// entry tag lined up with shift_out
	logic [ROW_W-1:0] tag_row;
	logic             tag_last;
	logic [CHD-1:0]   acc;
	logic [CHD-1:0]   row_sum;
	logic             all_zero;	// running verdict of the current run
	logic             run_open;
	logic             last_row;

	assign row_sum  = acc ^ shift_out;
	assign last_row = synd_valid && (synd_row == ROW_W'(N_BROW - 1));

	always_ff @(posedge sys_clk) begin
		if (!rst_n) begin
			tag_valid  <= 1'b0;
			run_open   <= 1'b0;
			acc        <= '0;
			all_zero   <= 1'b1;
			synd_valid <= 1'b0;
			done       <= 1'b0;
			check_ok   <= 1'b0;
		end else begin
			tag_valid  <= ent.valid;
			synd_valid <= tag_valid && tag_last;
			done       <= last_row;

			if (start && !run_open) begin	// same acceptance as the sequencer
				run_open <= 1'b1;
				all_zero <= 1'b1;
				check_ok <= 1'b0;
				acc      <= '0;
			end else if (last_row) begin
				run_open <= 1'b0;
				check_ok <= all_zero;
			end

			if (tag_valid) begin
				if (tag_last) begin
					acc      <= '0;	// next row starts clean
					all_zero <= all_zero & ~|row_sum;
				end else begin
					acc <= row_sum;
				end
			end
		end
	end

	always_ff @(posedge sys_clk) begin
		tag_row  <= ent.row;
		tag_last <= ent.row_last;
		if (tag_valid && tag_last) begin
			synd_row  <= tag_row;
			synd_data <= row_sum;
			synd_zero <= ~|row_sum;
		end
	end

endmodule

`default_nettype wire

// File: logic/cyclic_shift.sv
`timescale 1ns/100ps
`default_nettype none

module cyclic_shift #(
	parameter int IND = 1,	// bits per lane
	parameter int CHD = 360	// lanes per block
) (
	input wire                              sys_clk,
	input wire                              fs_en,
	input wire                              rst_n,
	input wire [ldpc_qc_pkg::SHIFT_W-1:0]   shift_index,	// rotation toward the MSB
	input wire [CHD*IND-1:0]                din,	// MSB is the first bit
	output logic [CHD*IND-1:0]              shift_out
);
	import ldpc_qc_pkg::*;

	localparam int SPAN  = 1 << SHIFT_W;
	localparam int TOP_W = (CHD + SPAN - 1) * IND;	// window ahead of the first stage

	logic [3*CHD*IND-1:0] din_buff;
	logic [TOP_W-1:0]     lvl [0:SHIFT_W];

	// three copies, so every window up to 511 stays inside the buffer
	assign din_buff = {din, din, din};
	assign lvl[0]   = din_buff[3*CHD*IND-1 -: TOP_W];

	/*
	 * each stage narrows the window by STEP lanes.
	 * a clear bit keeps the upper part, a set bit slides
	 * the window down, which rotates the result up by STEP
	 */
	for (genvar j = 0; j < SHIFT_W; j++) begin : g_stage
		localparam int STEP  = 1 << (SHIFT_W - 1 - j);
		localparam int IN_W  = (CHD + 2*STEP - 1) * IND;
		localparam int OUT_W = (CHD + STEP - 1) * IND;
		localparam int PAD_W = TOP_W - OUT_W;

		assign lvl[j+1] = shift_index[SHIFT_W-1-j] ?
			{{PAD_W{1'b0}}, lvl[j][OUT_W-1:0]} :
			{{PAD_W{1'b0}}, lvl[j][IN_W-1:STEP*IND]};
	end

	always_ff @(posedge sys_clk) begin
		if (!rst_n)
			shift_out <= '0;
		else if (fs_en)
			shift_out <= lvl[SHIFT_W][CHD*IND-1:0];	// hold while idle
	end

endmodule

`default_nettype wire

// File: logic/block_buffer.sv
`timescale 1ns/100ps
`default_nettype none

module block_buffer #(
	parameter int CHD = 360,
	parameter int IND = 1
) (
	input wire                             sys_clk,
	input wire                             rst_n,
	input wire                             blk_wr,
	input wire [ldpc_qc_pkg::COL_W-1:0]    blk_addr,
	input wire [CHD*IND-1:0]               blk_data,
	qc_entry_if.dst                        ent_in,
	qc_entry_if.src                        ent_out,
	output logic [CHD*IND-1:0]             blk_q
);
	import ldpc_qc_pkg::*;

	logic [CHD*IND-1:0] mem [N_BCOL];	// one circulant block per column

	always_ff @(posedge sys_clk) begin
		if (blk_wr)
			mem[blk_addr] <= blk_data;	// host only writes while idle
		if (ent_in.valid)
			blk_q <= mem[ent_in.col];
	end

	// entry tag follows the read by one stage
	always_ff @(posedge sys_clk) begin
		if (!rst_n)
			ent_out.valid <= 1'b0;
		else
			ent_out.valid <= ent_in.valid;
	end

	always_ff @(posedge sys_clk) begin
		ent_out.col      <= ent_in.col;
		ent_out.shift    <= ent_in.shift;
		ent_out.row      <= ent_in.row;
		ent_out.row_last <= ent_in.row_last;
	end

endmodule

`default_nettype wire

// File: logic/parity_sequencer.sv
`timescale 1ns/100ps
`default_nettype none

module parity_sequencer (
	input wire      sys_clk,
	input wire      rst_n,
	input wire      start,
	output logic    busy,
	qc_entry_if.src ent
);
	import ldpc_qc_pkg::*;

	localparam int PIPE_LAT = 3;	// read, rotate, accumulate
	localparam int CNT_LAST = N_ENT + PIPE_LAT - 1;
	localparam int CNT_W    = $clog2(CNT_LAST + 1);
	localparam int IDX_W    = $clog2(N_ENT);

	logic             running;
	logic [CNT_W-1:0] ent_cnt;
	hb_entry_t        cur;

	// counter keeps going past the table so busy covers the drain
	always_ff @(posedge sys_clk) begin
		if (!rst_n) begin
			running <= 1'b0;
			ent_cnt <= '0;
		end else if (!running) begin
			if (start) begin	// start during a run never gets here
				running <= 1'b1;
				ent_cnt <= '0;
			end
		end else if (ent_cnt == CNT_W'(CNT_LAST)) begin
			running <= 1'b0;
			ent_cnt <= '0;
		end else begin
			ent_cnt <= ent_cnt + 1'b1;
		end
	end

	assign cur = HB_TABLE[ent_cnt[IDX_W-1:0]];

	assign ent.valid    = running && (ent_cnt < CNT_W'(N_ENT));
	assign ent.col      = cur.col;
	assign ent.shift    = cur.shift;
	assign ent.row      = cur.row;
	assign ent.row_last = cur.row_last;

	assign busy = running;	// falls in the cycle done pulses

endmodule

`default_nettype wire

// File: logic/qc_entry_if.sv
`timescale 1ns/100ps
`default_nettype none

// one base-matrix entry moving down the pipeline
interface qc_entry_if;
	import ldpc_qc_pkg::*;

	logic               valid;
	logic [COL_W-1:0]   col;
	logic [SHIFT_W-1:0] shift;
	logic [ROW_W-1:0]   row;
	logic               row_last;

	modport src (
		output valid, col, shift, row, row_last
	);

	modport dst (
		input valid, col, shift, row, row_last
	);

endinterface

`default_nettype wire

// File: logic/ldpc_qc_pkg.sv
`default_nettype none

package ldpc_qc_pkg;

	localparam int CIRC_SIZE = 360;	// bits per circulant
	localparam int SHIFT_W   = 9;	// enough for shifts up to 511
	localparam int N_BCOL    = 4;	// block columns in the codeword
	localparam int COL_W     = 2;
	localparam int N_BROW    = 3;	// block rows, one syndrome each
	localparam int ROW_W     = 2;
	localparam int N_ENT     = 8;	// nonzero circulants in the base matrix

	typedef struct packed {
		logic [COL_W-1:0]   col;
		logic [SHIFT_W-1:0] shift;	// always below CIRC_SIZE
		logic [ROW_W-1:0]   row;
		logic               row_last;	// closes the row syndrome
	} hb_entry_t;

	// base matrix, row major, each row closed by its row_last entry
	localparam hb_entry_t HB_TABLE [N_ENT] = '{
		'{col: 2'd0, shift: 9'd0,   row: 2'd0, row_last: 1'b0},
		'{col: 2'd1, shift: 9'd137, row: 2'd0, row_last: 1'b0},
		'{col: 2'd2, shift: 9'd359, row: 2'd0, row_last: 1'b1},
		'{col: 2'd1, shift: 9'd52,  row: 2'd1, row_last: 1'b0},
		'{col: 2'd3, shift: 9'd288, row: 2'd1, row_last: 1'b1},
		'{col: 2'd0, shift: 9'd201, row: 2'd2, row_last: 1'b0},
		'{col: 2'd2, shift: 9'd17,  row: 2'd2, row_last: 1'b0},
		'{col: 2'd3, shift: 9'd96,  row: 2'd2, row_last: 1'b1}
	};

endpackage

`default_nettype wire
